// ==== hw/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_RESET_PC   32'h8000_0000

`define RV_OP_OP      7'b0110011
`define RV_OP_OP_IMM  7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_SYSTEM  7'b1110011

// branch conditions
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_BLT     3'b100
`define RV_F3_BGE     3'b101
`define RV_F3_BLTU    3'b110
`define RV_F3_BGEU    3'b111

// alu operations
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

`define RV_EBREAK     32'h0010_0073

`endif

// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // nine classes need a fourth bit
    typedef enum logic [3:0] {
        CLASS_ALU,
        CLASS_UPPER,   // lui or auipc
        CLASS_JAL,
        CLASS_JALR,
        CLASS_BRANCH,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_HALT,
        CLASS_NOP
    } inst_class_t;

    typedef enum logic [2:0] {
        ST_FETCH_REQ,
        ST_FETCH_REL,
        ST_EXECUTE,
        ST_DATA_REQ,
        ST_DATA_REL,
        ST_HALT
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/rv_decode_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface rv_decode_if;
    import rv_pkg::*;

    inst_class_t inst_class;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    word_t       imm;
    alu_op_t     alu_op;
    logic [2:0]  funct3;
    logic        is_lui;   // picks zero over pc in the upper class

    modport decoder (
        output inst_class, rs1, rs2, rd, imm, alu_op, funct3, is_lui
    );

    modport consumer (
        input inst_class, rs1, rs2, rd, imm, alu_op, funct3, is_lui
    );

endinterface

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defines.svh"

module rv_decoder (
    input  rv_pkg::word_t inst,
    rv_decode_if.decoder  dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic       funct7_5;   // sub and sra select

    assign opcode   = inst[6:0];
    assign funct7_5 = inst[30];

    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = (opcode == `RV_OP_OP_IMM) ? '0 : inst[24:20]; // immediate form reads x0
    assign dec.funct3 = inst[14:12];
    assign dec.is_lui = (opcode == `RV_OP_LUI);

    always_comb begin
        case (opcode)
            `RV_OP_OP, `RV_OP_OP_IMM: dec.inst_class = CLASS_ALU;
            `RV_OP_LUI, `RV_OP_AUIPC: dec.inst_class = CLASS_UPPER;
            `RV_OP_JAL:               dec.inst_class = CLASS_JAL;
            `RV_OP_JALR:              dec.inst_class = CLASS_JALR;
            `RV_OP_BRANCH:            dec.inst_class = CLASS_BRANCH;
            `RV_OP_LOAD:              dec.inst_class = CLASS_LOAD;
            `RV_OP_STORE:             dec.inst_class = CLASS_STORE;
            `RV_OP_SYSTEM: begin
                dec.inst_class = (inst == `RV_EBREAK) ? CLASS_HALT : CLASS_NOP;
            end
            default:                  dec.inst_class = CLASS_NOP; // unknown opcode
        endcase
    end

    // register form keeps a zero immediate so exec can merge operand b
    always_comb begin
        case (opcode)
            `RV_OP_OP_IMM, `RV_OP_JALR, `RV_OP_LOAD: begin
                dec.imm = {{20{inst[31]}}, inst[31:20]};
            end
            `RV_OP_STORE:  dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            `RV_OP_BRANCH: begin
                dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            `RV_OP_LUI, `RV_OP_AUIPC: dec.imm = {inst[31:12], 12'b0};
            `RV_OP_JAL: begin
                dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:       dec.imm = '0;
        endcase
    end

    always_comb begin
        dec.alu_op = ALU_ADD;   // address and target sums
        if (opcode == `RV_OP_OP || opcode == `RV_OP_OP_IMM) begin
            case (inst[14:12])
                `RV_F3_ADD:  dec.alu_op = (opcode == `RV_OP_OP && funct7_5) ? ALU_SUB : ALU_ADD;
                `RV_F3_SLL:  dec.alu_op = ALU_SLL;
                `RV_F3_SLT:  dec.alu_op = ALU_SLT;
                `RV_F3_SLTU: dec.alu_op = ALU_SLTU;
                `RV_F3_XOR:  dec.alu_op = ALU_XOR;
                `RV_F3_SR:   dec.alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
                `RV_F3_OR:   dec.alu_op = ALU_OR;
                `RV_F3_AND:  dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defines.svh"

module rv_exec (
    rv_decode_if.consumer dec,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t src1,
    input  rv_pkg::word_t src2,
    output rv_pkg::word_t result,
    output rv_pkg::word_t next_pc,
    output rv_pkg::word_t mem_addr
);
    import rv_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_res;
    word_t pc_plus4;
    logic  taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        alu_a = src1;
        alu_b = dec.imm;
        case (dec.inst_class)
            CLASS_ALU:                 alu_b = src2 | dec.imm; // one side is always zero
            CLASS_UPPER:               alu_a = dec.is_lui ? '0 : pc;
            CLASS_JAL, CLASS_BRANCH:   alu_a = pc;
            default: ;                 // jalr, load, store: rs1 + imm
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = alu_a + alu_b;
            ALU_SUB:  alu_res = alu_a - alu_b;
            ALU_SLL:  alu_res = alu_a << alu_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_res = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_res = alu_a ^ alu_b;
            ALU_SRL:  alu_res = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_res = $signed(alu_a) >>> alu_b[4:0];
            ALU_OR:   alu_res = alu_a | alu_b;
            ALU_AND:  alu_res = alu_a & alu_b;
            default:  alu_res = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  taken = (src1 == src2);
            `RV_F3_BNE:  taken = (src1 != src2);
            `RV_F3_BLT:  taken = ($signed(src1) < $signed(src2));
            `RV_F3_BGE:  taken = ($signed(src1) >= $signed(src2));
            `RV_F3_BLTU: taken = (src1 < src2);
            `RV_F3_BGEU: taken = (src1 >= src2);
            default:     taken = 1'b0;
        endcase
    end

    always_comb begin
        result  = alu_res;
        next_pc = pc_plus4;
        case (dec.inst_class)
            CLASS_JAL: begin
                result  = pc_plus4;   // link
                next_pc = alu_res;
            end
            CLASS_JALR: begin
                result  = pc_plus4;
                next_pc = {alu_res[31:1], 1'b0};
            end
            CLASS_BRANCH: begin
                if (taken) next_pc = alu_res;
            end
            default: ;
        endcase
    end

    assign mem_addr = alu_res;   // rs1 + imm for load and store

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic             clk,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);
    import rv_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // x0 is never a write target
    a_x0_zero: assert property (@(posedge clk)
        we |-> waddr != '0);

endmodule

`default_nettype wire

// ==== hw/rv_control.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defines.svh"

module rv_control (
    input  logic          clk,
    input  logic          reset,
    rv_decode_if.consumer dec,
    input  rv_pkg::word_t result,
    input  rv_pkg::word_t next_pc,
    input  rv_pkg::word_t data_addr,
    input  rv_pkg::word_t store_data,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t inst,
    output logic          rf_we,
    output rv_pkg::word_t rf_wdata,
    output logic          mem_req,
    output logic          mem_we,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    input  logic          mem_ack,
    input  rv_pkg::word_t mem_rdata,
    output logic          halted
);
    import rv_pkg::*;

    ctrl_state_t state;
    logic        writes_rd;
    logic        load_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_DATA_REL;   // bus idle, fetch once ack is low
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                ST_FETCH_REQ: begin
                    if (mem_ack) state <= ST_FETCH_REL;
                end
                ST_FETCH_REL: begin
                    if (!mem_ack) state <= ST_EXECUTE;   // ack low, bus free
                end
                ST_EXECUTE: begin
                    case (dec.inst_class)
                        CLASS_HALT: state <= ST_HALT;
                        CLASS_LOAD, CLASS_STORE: begin
                            pc    <= next_pc;
                            state <= ST_DATA_REQ;
                        end
                        default: begin
                            pc    <= next_pc;
                            state <= ST_FETCH_REQ;
                        end
                    endcase
                end
                ST_DATA_REQ: begin
                    if (mem_ack) state <= ST_DATA_REL;
                end
                ST_DATA_REL: begin
                    if (!mem_ack) state <= ST_FETCH_REQ;
                end
                default: state <= ST_HALT;   // stays until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FETCH_REQ && mem_ack) begin
            inst <= mem_rdata;
        end
    end

    always_comb begin
        case (dec.inst_class)
            CLASS_ALU, CLASS_UPPER, CLASS_JAL, CLASS_JALR: writes_rd = 1'b1;
            default:                                       writes_rd = 1'b0;
        endcase
    end

    assign load_done = (state == ST_DATA_REQ) && mem_ack && (dec.inst_class == CLASS_LOAD);

    assign rf_we    = (dec.rd != '0) && ((state == ST_EXECUTE && writes_rd) || load_done);
    assign rf_wdata = load_done ? mem_rdata : result;

    assign mem_req   = (state == ST_FETCH_REQ) || (state == ST_DATA_REQ);
    assign mem_we    = (state == ST_DATA_REQ) && (dec.inst_class == CLASS_STORE);
    assign mem_addr  = (state == ST_DATA_REQ) ? data_addr : pc;
    assign mem_wdata = store_data;
    assign halted    = (state == ST_HALT);

    // request drops only once the memory has answered
    a_req_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(mem_req) |-> $past(mem_ack));

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req && $past(mem_req) |-> $stable(mem_addr));

    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted && !mem_req);

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic          clk,
    input  logic          reset,
    output logic          mem_req,
    output logic          mem_we,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    input  logic          mem_ack,
    input  rv_pkg::word_t mem_rdata,
    output logic          halted
);
    import rv_pkg::*;

    word_t pc;
    word_t inst;
    word_t src1;
    word_t src2;
    word_t result;
    word_t next_pc;
    word_t data_addr;
    logic  rf_we;
    word_t rf_wdata;

    rv_decode_if dec_if ();

    rv_decoder decoder_inst (
        .inst (inst),
        .dec  (dec_if.decoder)
    );

    rv_regfile regfile_inst (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (dec_if.rd),
        .wdata  (rf_wdata),
        .raddr1 (dec_if.rs1),
        .raddr2 (dec_if.rs2),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    rv_exec exec_inst (
        .dec      (dec_if.consumer),
        .pc       (pc),
        .src1     (src1),
        .src2     (src2),
        .result   (result),
        .next_pc  (next_pc),
        .mem_addr (data_addr)
    );

    rv_control control_inst (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec_if.consumer),
        .result     (result),
        .next_pc    (next_pc),
        .data_addr  (data_addr),
        .store_data (src2),       // sw writes rs2
        .pc         (pc),
        .inst       (inst),
        .rf_we      (rf_we),
        .rf_wdata   (rf_wdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .halted     (halted)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;   // 40 ns period

endmodule

`default_nettype wire

// ==== tb/tb_rv_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defines.svh"

module tb_rv_memory (
    input  logic          clk,
    input  logic          reset,
    input  logic          mem_req,
    input  logic          mem_we,
    input  rv_pkg::word_t mem_addr,
    input  rv_pkg::word_t mem_wdata,
    output logic          mem_ack,
    output rv_pkg::word_t mem_rdata
);
    import rv_pkg::*;

    word_t      mem [0:255];   // 1 KB at RV_RESET_PC
    integer     seed = 32'h159c_bb20;
    word_t      rnd;
    logic [1:0] phase = 2'd0;
    logic [1:0] delay = 2'd0;

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
    end

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic word_t i_type(input logic [2:0] f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw rs2, imm(rs1)
    function automatic word_t s_type(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    // branch forward by 8, skipping one instruction
    function automatic word_t b_fwd8(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {7'b0, rs2, rs1, f3, 5'b01000, `RV_OP_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = ~(`RV_RESET_PC + 32'(4 * i));   // address-based fill
        end
        mem[0]  = u_type(20'h80000, 1, `RV_OP_LUI);
        mem[1]  = i_type(`RV_F3_ADD, 1, 1, 12'd512, `RV_OP_OP_IMM);   // x1 = result base
        mem[2]  = i_type(`RV_F3_ADD, 2, 0, 12'hff9, `RV_OP_OP_IMM);   // x2 = -7
        mem[3]  = i_type(`RV_F3_ADD, 3, 0, 12'd5, `RV_OP_OP_IMM);     // x3 = 5
        mem[4]  = r_type(7'h00, `RV_F3_ADD, 4, 2, 3);
        mem[5]  = s_type(4, 1, 12'd0);
        mem[6]  = r_type(7'h20, `RV_F3_ADD, 4, 2, 3);
        mem[7]  = s_type(4, 1, 12'd4);
        mem[8]  = r_type(7'h00, `RV_F3_SLL, 4, 3, 3);
        mem[9]  = s_type(4, 1, 12'd8);
        mem[10] = r_type(7'h00, `RV_F3_SR, 4, 2, 3);
        mem[11] = s_type(4, 1, 12'd12);
        mem[12] = r_type(7'h20, `RV_F3_SR, 4, 2, 3);
        mem[13] = s_type(4, 1, 12'd16);
        mem[14] = r_type(7'h00, `RV_F3_SLT, 4, 2, 3);
        mem[15] = s_type(4, 1, 12'd20);
        mem[16] = r_type(7'h00, `RV_F3_SLTU, 4, 2, 3);
        mem[17] = s_type(4, 1, 12'd24);
        mem[18] = r_type(7'h00, `RV_F3_XOR, 4, 2, 3);
        mem[19] = s_type(4, 1, 12'd28);
        mem[20] = r_type(7'h00, `RV_F3_OR, 4, 2, 3);
        mem[21] = s_type(4, 1, 12'd32);
        mem[22] = r_type(7'h00, `RV_F3_AND, 4, 2, 3);
        mem[23] = s_type(4, 1, 12'd36);
        mem[24] = u_type(20'h12345, 4, `RV_OP_LUI);
        mem[25] = s_type(4, 1, 12'd40);
        mem[26] = u_type(20'h00001, 4, `RV_OP_AUIPC);
        mem[27] = s_type(4, 1, 12'd44);
        mem[28] = i_type(`RV_F3_SR, 4, 2, 12'h401, `RV_OP_OP_IMM);    // srai by 1
        mem[29] = s_type(4, 1, 12'd48);
        mem[30] = i_type(`RV_F3_ADD, 6, 0, 12'd0, `RV_OP_OP_IMM);     // not-taken mask
        mem[31] = i_type(`RV_F3_ADD, 7, 0, 12'd0, `RV_OP_OP_IMM);     // taken mask
        mem[32] = b_fwd8(`RV_F3_BEQ, 3, 3);
        mem[33] = i_type(`RV_F3_ADD, 7, 7, 12'd1, `RV_OP_OP_IMM);
        mem[34] = b_fwd8(`RV_F3_BEQ, 2, 3);
        mem[35] = i_type(`RV_F3_ADD, 6, 6, 12'd1, `RV_OP_OP_IMM);
        mem[36] = b_fwd8(`RV_F3_BNE, 2, 3);
        mem[37] = i_type(`RV_F3_ADD, 7, 7, 12'd2, `RV_OP_OP_IMM);
        mem[38] = b_fwd8(`RV_F3_BNE, 3, 3);
        mem[39] = i_type(`RV_F3_ADD, 6, 6, 12'd2, `RV_OP_OP_IMM);
        mem[40] = b_fwd8(`RV_F3_BLT, 2, 3);
        mem[41] = i_type(`RV_F3_ADD, 7, 7, 12'd4, `RV_OP_OP_IMM);
        mem[42] = b_fwd8(`RV_F3_BLT, 3, 2);
        mem[43] = i_type(`RV_F3_ADD, 6, 6, 12'd4, `RV_OP_OP_IMM);
        mem[44] = b_fwd8(`RV_F3_BGE, 3, 2);
        mem[45] = i_type(`RV_F3_ADD, 7, 7, 12'd8, `RV_OP_OP_IMM);
        mem[46] = b_fwd8(`RV_F3_BGE, 2, 3);
        mem[47] = i_type(`RV_F3_ADD, 6, 6, 12'd8, `RV_OP_OP_IMM);
        mem[48] = b_fwd8(`RV_F3_BLTU, 3, 2);
        mem[49] = i_type(`RV_F3_ADD, 7, 7, 12'd16, `RV_OP_OP_IMM);
        mem[50] = b_fwd8(`RV_F3_BLTU, 2, 3);
        mem[51] = i_type(`RV_F3_ADD, 6, 6, 12'd16, `RV_OP_OP_IMM);
        mem[52] = b_fwd8(`RV_F3_BGEU, 2, 3);
        mem[53] = i_type(`RV_F3_ADD, 7, 7, 12'd32, `RV_OP_OP_IMM);
        mem[54] = b_fwd8(`RV_F3_BGEU, 3, 2);
        mem[55] = i_type(`RV_F3_ADD, 6, 6, 12'd32, `RV_OP_OP_IMM);
        mem[56] = {1'b0, 10'd4, 1'b0, 8'd0, 5'd8, `RV_OP_JAL};        // jal x8, +8
        mem[57] = i_type(`RV_F3_ADD, 7, 7, 12'd64, `RV_OP_OP_IMM);
        mem[58] = u_type(20'h00000, 10, `RV_OP_AUIPC);
        mem[59] = i_type(3'b000, 9, 10, 12'd12, `RV_OP_JALR);         // to word 61
        mem[60] = i_type(`RV_F3_ADD, 7, 7, 12'd128, `RV_OP_OP_IMM);
        mem[61] = s_type(6, 1, 12'd52);
        mem[62] = s_type(7, 1, 12'd56);
        mem[63] = s_type(8, 1, 12'd60);
        mem[64] = s_type(9, 1, 12'd64);
        mem[65] = i_type(3'b010, 11, 1, 12'd0, `RV_OP_LOAD);
        mem[66] = s_type(11, 1, 12'd68);
        mem[67] = `RV_EBREAK;
    end

    // four-phase responder, each phase delayed 0 to 3 cycles
    always @(negedge clk) begin
        rnd = $random(seed);
        if (reset) begin
            phase   <= 2'd0;
            mem_ack <= 1'b0;
        end else begin
            case (phase)
                2'd0: begin
                    if (mem_req) begin
                        delay <= rnd[1:0];
                        phase <= 2'd1;
                    end
                end
                2'd1: begin
                    if (delay != 2'd0) begin
                        delay <= delay - 2'd1;
                    end else begin
                        if (mem_we) begin
                            mem[mem_addr[9:2]] <= mem_wdata;
                        end else begin
                            mem_rdata <= mem[mem_addr[9:2]];
                        end
                        mem_ack <= 1'b1;
                        phase   <= 2'd2;
                    end
                end
                2'd2: begin
                    if (!mem_req) begin
                        delay <= rnd[1:0];
                        phase <= 2'd3;
                    end
                end
                default: begin
                    if (delay != 2'd0) begin
                        delay <= delay - 2'd1;
                    end else begin
                        mem_ack <= 1'b0;
                        phase   <= 2'd0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int    NUM_RESULTS = 18;
    localparam int    TIMEOUT     = 5000;
    localparam int    QUIET_WINDOW = 20;
    localparam word_t RESULT_BASE = `RV_RESET_PC + 32'h200;

    logic  clk;
    logic  reset;
    logic  mem_req;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_ack;
    word_t mem_rdata;
    logic  halted;
    logic  ack_q = 1'b0;
    int    slot;

    // one slot per sw of the program, in store order
    word_t expected [NUM_RESULTS] = '{
        32'hFFFF_FFFE, 32'hFFFF_FFF4, 32'h0000_00A0, 32'h07FF_FFFF,
        32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 32'hFFFF_FFFC,
        32'hFFFF_FFFD, 32'h0000_0001, 32'h1234_5000, 32'h8000_1068,
        32'hFFFF_FFFC, 32'h0000_003F, 32'h0000_0000, 32'h8000_00E4,
        32'h8000_00F0, 32'hFFFF_FFFE
    };
    string names [NUM_RESULTS] = '{
        "add", "sub", "sll", "srl", "sra", "slt", "sltu", "xor", "or", "and",
        "lui", "auipc", "srai", "branch not-taken mask", "branch taken mask",
        "jal link", "jalr link", "lw"
    };
    word_t written [NUM_RESULTS];
    int    write_count [NUM_RESULTS] = '{default: 0};

    tb_clock clock_inst (.clk(clk));

    rv_core rv_core_inst (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    tb_rv_memory memory_inst (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        a_value: assert (act === exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    a_req_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else report_failure("mem_req rose while mem_ack was still high");

    a_req_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(mem_req) |-> $past(mem_ack))
        else report_failure("mem_req fell before mem_ack had risen");

    // record each store once, on the rising ack
    always @(posedge clk) begin
        ack_q <= mem_ack;
        if (!reset && mem_req && mem_we && mem_ack && !ack_q) begin
            a_store_addr: assert (mem_addr >= RESULT_BASE &&
                                  mem_addr < RESULT_BASE + 4 * NUM_RESULTS)
                else report_failure("store to an address outside the result area");
            slot = int'((mem_addr - RESULT_BASE) >> 2);
            written[slot]     = mem_wdata;
            write_count[slot] = write_count[slot] + 1;
        end
    end

    initial begin
        int cycles;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        a_reset_state: assert (!mem_req && !halted && !mem_we)
            else report_failure("mem_req, halted or mem_we high right after reset");
        cycles = 0;
        while (!mem_req && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        a_first_req: assert (mem_req)
            else report_failure("timeout waiting for the first fetch request");
        check_value("first fetch address", `RV_RESET_PC, mem_addr);
        check_value("first fetch write flag", 32'd0, {31'd0, mem_we});
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        a_halted: assert (halted) else report_failure("timeout waiting for halted");
        for (int i = 0; i < QUIET_WINDOW; i++) begin
            @(negedge clk);
            a_quiet: assert (!mem_req && halted)
                else report_failure("memory request or halt drop after ebreak");
        end
        for (int i = 0; i < NUM_RESULTS; i++) begin
            a_once: assert (write_count[i] == 1)
                else report_failure($sformatf("result %s written %0d times",
                                              names[i], write_count[i]));
            check_value(names[i], expected[i], written[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_decode_if.sv
hw/rv_decoder.sv
hw/rv_exec.sv
hw/rv_regfile.sv
hw/rv_control.sv
hw/rv_core.sv
tb/tb_clock.sv
tb/tb_rv_memory.sv
tb/tb_rv_core.sv

// ==== Makefile ====
SIM_BIN = obj_dir/tb_rv_core_sim

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module rv_core

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_rv_core \
		-o tb_rv_core_sim
	@out=$$(./$(SIM_BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
